// File: hps_pkg.sv
// shared types, command codes and constants for the host I/O bridge
package hps_pkg;

	//////////////////////////////
	// bus and payload widths
	//////////////////////////////

	typedef logic [15:0] host_word_t;
	typedef logic [15:0] cmd_code_t;
	// word position inside a frame, saturates at all ones
	typedef logic [9:0]  word_idx_t;
	typedef logic [24:0] dl_addr_t;
	typedef logic [7:0]  dl_data_t;
	typedef logic [7:0]  ps2_byte_t;
	// holds 0 to 32 inclusive
	typedef logic [5:0]  fifo_cnt_t;

	//////////////////////////////
	// state machines
	//////////////////////////////

	typedef enum logic [1:0] {
		IDLE,
		CMD,
		DATA
	} frame_state_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} ps2_tx_state_t;

	//////////////////////////////
	// host command codes
	//////////////////////////////

	localparam cmd_code_t CMD_JOY0        = 16'h0002;
	localparam cmd_code_t CMD_PS2_KBD     = 16'h0005;
	localparam cmd_code_t CMD_STATUS      = 16'h001e;
	localparam cmd_code_t CMD_KBD_CREDIT  = 16'h0021;
	localparam cmd_code_t CMD_FILE_TX     = 16'h0053;
	localparam cmd_code_t CMD_FILE_TX_DAT = 16'h0054;
	localparam cmd_code_t CMD_FILE_INDEX  = 16'h0055;
	localparam cmd_code_t CMD_FILE_INFO   = 16'h0056;

	// keyboard fifo
	localparam int PS2_FIFO_DEPTH = 32;
	localparam int PS2_PTR_W      = $clog2(PS2_FIFO_DEPTH);

	// emulated ps2 clock, clk_sys cycles per half period
	localparam int PS2_HALF_PERIOD = 24;
	localparam int PS2_DIV_W       = $clog2(PS2_HALF_PERIOD);

endpackage

// File: host_cmd_if.sv
// decoded host command words passed from the frame decoder to the data blocks
interface host_cmd_if import hps_pkg::*; ();

	// high while a frame is open and its first cycle has passed
	logic       in_frame;
	// one cycle per data word, in the strobe cycle
	logic       wr_valid;
	cmd_code_t  cmd;
	word_idx_t  word_idx;
	host_word_t wdata;

	modport decoder (
		output in_frame,
		output wr_valid,
		output cmd,
		output word_idx,
		output wdata
	);

	modport sink (
		input in_frame,
		input wr_valid,
		input cmd,
		input word_idx,
		input wdata
	);

endinterface

// File: host_frame_fsm.sv
// host frame decoder tracking command and word index, with registered read-back
module host_frame_fsm import hps_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst,
	input  logic        io_enable,
	input  logic        io_strobe,
	input  host_word_t  io_din,
	input  logic        ioctl_wait,
	input  fifo_cnt_t   kbd_credit,
	output host_word_t  io_dout,
	host_cmd_if.decoder bus
);

	frame_state_t state;
	cmd_code_t    cmd_q;
	word_idx_t    word_cnt;
	logic         cmd_strobe;
	logic         data_strobe;

	// first strobe of a frame is the command, the rest are data
	assign cmd_strobe  = io_enable && io_strobe && (state != DATA);
	assign data_strobe = io_enable && io_strobe && (state == DATA);

	//////////////////////////////
	// frame tracking
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state    <= IDLE;
			cmd_q    <= '0;
			word_cnt <= '0;
		end else if (!io_enable) begin
			state <= IDLE;
		end else if (cmd_strobe) begin
			state    <= DATA;
			cmd_q    <= io_din;
			word_cnt <= word_idx_t'(1);
		end else if (data_strobe) begin
			// long frames park at the last index
			if (word_cnt != '1)
				word_cnt <= word_cnt + 1'b1;
		end else if (state == IDLE) begin
			state <= CMD;
		end
	end

	assign bus.in_frame = io_enable && (state != IDLE);
	assign bus.wr_valid = data_strobe;
	assign bus.cmd      = cmd_q;
	assign bus.word_idx = word_cnt;
	assign bus.wdata    = io_din;

	//////////////////////////////
	// read-back word
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst || !io_enable) begin
			io_dout <= '0;
		end else if (io_strobe) begin
			// credit is only returned on word 1 of its command
			if (data_strobe && cmd_q == CMD_KBD_CREDIT && word_cnt == word_idx_t'(1))
				io_dout <= host_word_t'(kbd_credit);
			else
				io_dout <= '0;
		end
	end

	// core back-pressure must stall the host before its next strobe
	a_no_strobe_in_wait: assert property (@(posedge clk_sys) disable iff (rst)
		ioctl_wait |-> !(io_enable && io_strobe))
		else $error("host strobe while ioctl_wait is high");

endmodule

// File: host_regs.sv
// joystick 0 and status registers loaded from host command frames
module host_regs import hps_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst,
	host_cmd_if.sink    bus,
	output logic [31:0] joystick_0,
	output logic [31:0] status
);

	logic wr;
	logic lo_half;
	logic hi_half;

	assign wr      = bus.in_frame && bus.wr_valid;
	// word 1 carries the low half, word 2 the high half
	assign lo_half = (bus.word_idx == word_idx_t'(1));
	assign hi_half = (bus.word_idx == word_idx_t'(2));

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			joystick_0 <= '0;
			status     <= '0;
		end else if (wr) begin
			case (bus.cmd)
				CMD_JOY0: begin
					if (lo_half)
						joystick_0[15:0] <= bus.wdata;
					else if (hi_half)
						joystick_0[31:16] <= bus.wdata;
				end
				CMD_STATUS: begin
					if (lo_half)
						status[15:0] <= bus.wdata;
					else if (hi_half)
						status[31:16] <= bus.wdata;
				end
				default: begin
					// other commands belong to other blocks
				end
			endcase
		end
	end

endmodule

// File: file_download.sv
// file download control: index, extension, address counter and write strobe
module file_download import hps_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst,
	host_cmd_if.sink    bus,
	output logic        ioctl_download,
	output logic        ioctl_wr,
	output logic [7:0]  ioctl_index,
	output dl_addr_t    ioctl_addr,
	output dl_data_t    ioctl_dout,
	output logic [31:0] ioctl_file_ext
);

	logic     wr;
	logic     wr_q;
	dl_addr_t addr;

	assign wr = bus.in_frame && bus.wr_valid;

	//////////////////////////////
	// download control
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ioctl_download <= 1'b0;
			wr_q           <= 1'b0;
			ioctl_wr       <= 1'b0;
			addr           <= '0;
		end else begin
			// write strobe trails the address and data by one cycle
			wr_q     <= wr && (bus.cmd == CMD_FILE_TX_DAT);
			ioctl_wr <= wr_q;
			if (wr && bus.cmd == CMD_FILE_TX) begin
				ioctl_download <= (bus.wdata[7:0] != 8'h00);
				if (bus.wdata[7:0] != 8'h00)
					addr <= '0;
			end else if (wr && bus.cmd == CMD_FILE_TX_DAT) begin
				addr <= addr + 1'b1;
			end
		end
	end

	//////////////////////////////
	// payload registers
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (wr) begin
			case (bus.cmd)
				CMD_FILE_INDEX: ioctl_index <= bus.wdata[7:0];
				CMD_FILE_INFO: begin
					// extension arrives high half first
					if (bus.word_idx == word_idx_t'(1))
						ioctl_file_ext[31:16] <= bus.wdata;
					else if (bus.word_idx == word_idx_t'(2))
						ioctl_file_ext[15:0] <= bus.wdata;
				end
				CMD_FILE_TX: begin
					// end of download reports the byte count
					if (bus.wdata[7:0] == 8'h00)
						ioctl_addr <= addr;
				end
				CMD_FILE_TX_DAT: begin
					ioctl_addr <= addr;
					ioctl_dout <= bus.wdata[7:0];
				end
				default: begin
				end
			endcase
		end
	end

	// a data word must never land outside an open download
	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (rst)
		ioctl_wr |-> ioctl_download)
		else $error("ioctl_wr pulsed with no download active");

endmodule

// File: ps2_clk_div.sv
// divider producing the emulated ps2 clock level from clk_sys
module ps2_clk_div import hps_pkg::*; (
	input  logic clk_sys,
	input  logic rst,
	output logic ps2_clk
);

	logic [PS2_DIV_W-1:0] cnt;

	// toggle once per half period
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cnt     <= '0;
			ps2_clk <= 1'b0;
		end else if (cnt == PS2_DIV_W'(PS2_HALF_PERIOD - 1)) begin
			cnt     <= '0;
			ps2_clk <= ~ps2_clk;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

// File: ps2_kbd_tx.sv
// keyboard byte fifo with credit count and ps2 device-to-host serializer
module ps2_kbd_tx import hps_pkg::*; (
	input  logic      clk_sys,
	input  logic      rst,
	input  logic      ps2_clk,
	host_cmd_if.sink  bus,
	output fifo_cnt_t kbd_credit,
	output logic      ps2_kbd_clk_out,
	output logic      ps2_kbd_data_out
);

	ps2_byte_t            fifo_mem [PS2_FIFO_DEPTH];
	logic [PS2_PTR_W-1:0] wptr;
	logic [PS2_PTR_W-1:0] rptr;
	fifo_cnt_t            count;
	logic                 push;
	logic                 push_ok;
	logic                 pop;
	logic                 full;
	logic                 empty;

	ps2_tx_state_t        state;
	ps2_byte_t            tx_byte;
	logic [2:0]           bit_cnt;
	logic                 parity;
	logic                 frame_act;
	logic                 ps2_clk_q;
	logic                 clk_rise;
	logic                 clk_fall;

	//////////////////////////////
	// key byte fifo
	//////////////////////////////

	assign push    = bus.in_frame && bus.wr_valid && (bus.cmd == CMD_PS2_KBD);
	assign full    = (count == fifo_cnt_t'(PS2_FIFO_DEPTH));
	assign empty   = (count == '0);
	assign push_ok = push && !full;
	// a new frame may start only after the previous one has settled
	assign pop     = clk_rise && (state == TX_IDLE) && !frame_act && !empty;

	assign kbd_credit = fifo_cnt_t'(PS2_FIFO_DEPTH) - count;

	always_ff @(posedge clk_sys) begin
		if (push_ok)
			fifo_mem[wptr] <= bus.wdata[7:0];
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (push_ok)
				wptr <= wptr + 1'b1;
			if (pop)
				rptr <= rptr + 1'b1;
			case ({push_ok, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	//////////////////////////////
	// serializer
	//////////////////////////////

	assign clk_rise = ps2_clk && !ps2_clk_q;
	assign clk_fall = !ps2_clk && ps2_clk_q;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ps2_clk_q        <= 1'b0;
			state            <= TX_IDLE;
			tx_byte          <= '0;
			bit_cnt          <= '0;
			parity           <= 1'b1;
			frame_act        <= 1'b0;
			ps2_kbd_data_out <= 1'b1;
			ps2_kbd_clk_out  <= 1'b1;
		end else begin
			ps2_clk_q <= ps2_clk;
			if (clk_rise) begin
				ps2_kbd_clk_out <= 1'b1;
				case (state)
					TX_IDLE: begin
						if (pop) begin
							// start bit
							tx_byte          <= fifo_mem[rptr];
							bit_cnt          <= '0;
							parity           <= 1'b1;
							frame_act        <= 1'b1;
							ps2_kbd_data_out <= 1'b0;
							state            <= TX_DATA;
						end else begin
							frame_act <= 1'b0;
						end
					end
					TX_DATA: begin
						// lsb first, parity accumulates as odd
						ps2_kbd_data_out <= tx_byte[0];
						parity           <= parity ^ tx_byte[0];
						tx_byte          <= tx_byte >> 1;
						bit_cnt          <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= TX_PARITY;
					end
					TX_PARITY: begin
						ps2_kbd_data_out <= parity;
						state            <= TX_STOP;
					end
					TX_STOP: begin
						ps2_kbd_data_out <= 1'b1;
						state            <= TX_IDLE;
					end
					default: state <= TX_IDLE;
				endcase
			end else if (clk_fall) begin
				// host samples data while the clock is low
				ps2_kbd_clk_out <= !frame_act;
			end
		end
	end

	// the host must respect the credit it read back
	a_no_overflow: assert property (@(posedge clk_sys) disable iff (rst)
		push |-> !full)
		else $error("keyboard byte pushed beyond host credit");

endmodule

// File: hps_io_lite.sv
// top level of the host-to-core bridge: host bus, core outputs and ps2 lines
module hps_io_lite import hps_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst,

	// host bus
	input  logic        io_enable,
	input  logic        io_strobe,
	input  host_word_t  io_din,
	output host_word_t  io_dout,
	output logic        io_wait,

	// core registers
	output logic [31:0] joystick_0,
	output logic [31:0] status,

	// file download to the core
	output logic        ioctl_download,
	output logic        ioctl_wr,
	output logic [7:0]  ioctl_index,
	output dl_addr_t    ioctl_addr,
	output dl_data_t    ioctl_dout,
	output logic [31:0] ioctl_file_ext,
	input  logic        ioctl_wait,

	// emulated keyboard
	output logic        ps2_kbd_clk_out,
	output logic        ps2_kbd_data_out
);

	fifo_cnt_t kbd_credit;
	logic      ps2_clk;

	host_cmd_if u_bus ();

	// core back-pressure goes straight to the host
	assign io_wait = ioctl_wait;

	//////////////////////////////
	// host side
	//////////////////////////////

	host_frame_fsm u_frame (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.io_enable  (io_enable),
		.io_strobe  (io_strobe),
		.io_din     (io_din),
		.ioctl_wait (ioctl_wait),
		.kbd_credit (kbd_credit),
		.io_dout    (io_dout),
		.bus        (u_bus.decoder)
	);

	//////////////////////////////
	// data blocks
	//////////////////////////////

	host_regs u_regs (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.bus        (u_bus.sink),
		.joystick_0 (joystick_0),
		.status     (status)
	);

	file_download u_dl (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.bus            (u_bus.sink),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext)
	);

	ps2_clk_div u_ps2_div (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ps2_clk (ps2_clk)
	);

	ps2_kbd_tx u_kbd (
		.clk_sys          (clk_sys),
		.rst              (rst),
		.ps2_clk          (ps2_clk),
		.bus              (u_bus.sink),
		.kbd_credit       (kbd_credit),
		.ps2_kbd_clk_out  (ps2_kbd_clk_out),
		.ps2_kbd_data_out (ps2_kbd_data_out)
	);

endmodule

// File: tb_checker.sv
// testbench monitor: samples bridge outputs, decodes ps2 frames and counts errors
module tb_checker import hps_pkg::*; (
	input logic        clk_sys,
	input logic        rst,
	input host_word_t  io_dout,
	input logic        io_wait,
	input logic        ioctl_wait,
	input logic [31:0] joystick_0,
	input logic [31:0] status,
	input logic        ioctl_download,
	input logic        ioctl_wr,
	input logic [7:0]  ioctl_index,
	input dl_addr_t    ioctl_addr,
	input dl_data_t    ioctl_dout,
	input logic [31:0] ioctl_file_ext,
	input logic        ps2_kbd_clk_out,
	input logic        ps2_kbd_data_out
);
	timeunit 1ns;
	timeprecision 1ps;

	int          value_errs = 0;
	int          other_errs = 0;
	int          checks = 0;
	int          writes_seen = 0;
	int          writes_expected = 0;
	dl_addr_t    wr_addr_q [$];
	dl_data_t    wr_data_q [$];
	ps2_byte_t   key_q [$];
	logic [10:0] frame_bits;
	int          bit_idx = 0;
	ps2_byte_t   exp_key;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			value_errs++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	//////////////////////////////
	// checks called from the top
	//////////////////////////////

	task automatic after_reset();
		compare("ioctl_download", ioctl_download, 32'h0);
		compare("ioctl_wr", ioctl_wr, 32'h0);
		compare("ps2_kbd_clk_out", ps2_kbd_clk_out, 32'h1);
		compare("ps2_kbd_data_out", ps2_kbd_data_out, 32'h1);
		compare("io_dout", io_dout, 32'h0);
		compare("joystick_0", joystick_0, 32'h0);
		compare("status", status, 32'h0);
	endtask

	task automatic match_regs(input logic [31:0] joy, input logic [31:0] st, input logic dl);
		compare("joystick_0", joystick_0, joy);
		compare("status", status, st);
		compare("ioctl_download", ioctl_download, 32'(dl));
	endtask

	task automatic match_byte_count(input dl_addr_t count);
		compare("ioctl_addr", ioctl_addr, 32'(count));
	endtask

	task automatic match_credit(input fifo_cnt_t credit);
		compare("io_dout", io_dout, 32'(credit));
	endtask

	task automatic match_file_info(input logic [7:0] index, input logic [31:0] ext);
		compare("ioctl_index", ioctl_index, 32'(index));
		compare("ioctl_file_ext", ioctl_file_ext, ext);
	endtask

	task automatic expect_write(input dl_addr_t addr, input dl_data_t data);
		wr_addr_q.push_back(addr);
		wr_data_q.push_back(data);
		writes_expected++;
	endtask

	task automatic expect_key(input ps2_byte_t key);
		key_q.push_back(key);
	endtask

	function automatic int keys_pending();
		return key_q.size();
	endfunction

	task automatic wrap_up();
		if (wr_addr_q.size() != 0) begin
			other_errs++;
			$display("%0d download bytes were never written to the core", wr_addr_q.size());
		end
		compare("ioctl_wr pulse count", writes_seen, writes_expected);
		if (bit_idx != 0) begin
			other_errs++;
			$display("a ps2 frame was left unfinished after %0d bits", bit_idx);
		end
		compare("ps2_kbd_clk_out", ps2_kbd_clk_out, 32'h1);
	endtask

	//////////////////////////////
	// stream monitors
	//////////////////////////////

	// outputs settle after the rising edge, so look at them mid-cycle
	always @(negedge clk_sys) begin
		if (!rst) begin
			if (ioctl_wait)
				compare("io_wait", io_wait, 32'h1);
			if (ioctl_wr === 1'b1) begin
				writes_seen++;
				if (wr_addr_q.size() == 0) begin
					other_errs++;
					$display("ioctl_wr pulsed with no download byte outstanding");
				end else begin
					compare("ioctl_addr", ioctl_addr, 32'(wr_addr_q.pop_front()));
					compare("ioctl_dout", ioctl_dout, 32'(wr_data_q.pop_front()));
				end
			end
		end
	end

	// data is held steady while the ps2 clock is low
	always @(negedge ps2_kbd_clk_out) begin
		if (!rst) begin
			frame_bits[bit_idx] = ps2_kbd_data_out;
			if (bit_idx == 10) begin
				bit_idx = 0;
				if (key_q.size() == 0) begin
					other_errs++;
					$display("ps2 frame sent while no key byte was queued");
				end else begin
					exp_key = key_q.pop_front();
					compare("ps2 start bit", 32'(frame_bits[0]), 32'h0);
					compare("ps2 data", 32'(frame_bits[8:1]), 32'(exp_key));
					compare("ps2 parity", 32'(frame_bits[9]), 32'(~^exp_key));
					compare("ps2 stop bit", 32'(frame_bits[10]), 32'h1);
				end
			end else begin
				bit_idx = bit_idx + 1;
			end
		end
	end

endmodule

// File: tb_hps_io.sv
// testbench top: clock, reset, host frame table and the bridge under test
module tb_hps_io import hps_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		cmd_code_t         cmd;
		logic [2:0]        n_words;
		logic [3:0][15:0]  w;
		logic              hold_wait;
		logic              sync_ps2;
		logic [31:0]       exp_joy;
		logic [31:0]       exp_status;
		logic              exp_dl;
		logic              chk_addr;
		dl_addr_t          exp_addr;
		logic              chk_credit;
		fifo_cnt_t         exp_credit;
	} frame_t;

	logic        clk_sys;
	logic        rst;
	logic        io_enable;
	logic        io_strobe;
	host_word_t  io_din;
	host_word_t  io_dout;
	logic        io_wait;
	logic        ioctl_wait;
	logic [31:0] joystick_0;
	logic [31:0] status;
	logic        ioctl_download;
	logic        ioctl_wr;
	logic [7:0]  ioctl_index;
	dl_addr_t    ioctl_addr;
	dl_data_t    ioctl_dout;
	logic [31:0] ioctl_file_ext;
	logic        ps2_kbd_clk_out;
	logic        ps2_kbd_data_out;

	frame_t      tbl [$];
	int          seed = 32'h2ec7;
	int          cycle_cnt = 0;
	int          timeout_limit = 0;
	// running model of what the bridge should hold
	logic [31:0] cur_joy = '0;
	logic [31:0] cur_status = '0;
	logic [31:0] cur_ext = '0;
	logic [7:0]  cur_index = '0;
	logic        cur_dl = 1'b0;
	int          dl_cnt = 0;
	int          keys_pushed = 0;

	always #10 clk_sys = ~clk_sys;

	hps_io_lite u_dut (.*);

	tb_checker u_chk (.*);

	function automatic host_word_t next_word();
		return host_word_t'($random(seed));
	endfunction

	//////////////////////////////
	// frame table
	//////////////////////////////

	task automatic add_frame(
		input cmd_code_t  cmd,
		input int         n,
		input host_word_t w0,
		input host_word_t w1,
		input logic       rnd,
		input logic       hold,
		input logic       sync
	);
		frame_t f;
		f = '0;
		f.cmd = cmd;
		f.n_words = 3'(n);
		f.w[0] = w0;
		f.w[1] = w1;
		f.hold_wait = hold;
		f.sync_ps2 = sync;
		if (rnd) begin
			for (int i = 0; i < n; i++)
				f.w[i] = next_word();
		end
		case (cmd)
			CMD_JOY0: cur_joy = {f.w[1], f.w[0]};
			CMD_STATUS: cur_status = {f.w[1], f.w[0]};
			CMD_FILE_INDEX: cur_index = f.w[0][7:0];
			// extension arrives high half first
			CMD_FILE_INFO: cur_ext = {f.w[0], f.w[1]};
			CMD_FILE_TX: begin
				cur_dl = (f.w[0][7:0] != 8'h00);
				if (cur_dl) begin
					dl_cnt = 0;
				end else begin
					f.chk_addr = 1'b1;
					f.exp_addr = dl_addr_t'(dl_cnt);
				end
			end
			CMD_FILE_TX_DAT: begin
				for (int i = 0; i < n; i++) begin
					u_chk.expect_write(dl_addr_t'(dl_cnt), f.w[i][7:0]);
					dl_cnt++;
				end
			end
			CMD_PS2_KBD: begin
				for (int i = 0; i < n; i++) begin
					u_chk.expect_key(f.w[i][7:0]);
					keys_pushed++;
				end
			end
			CMD_KBD_CREDIT: begin
				f.chk_credit = 1'b1;
				f.exp_credit = fifo_cnt_t'(PS2_FIFO_DEPTH - keys_pushed);
			end
			default: begin
			end
		endcase
		f.exp_joy = cur_joy;
		f.exp_status = cur_status;
		f.exp_dl = cur_dl;
		tbl.push_back(f);
	endtask

	//////////////////////////////
	// host bus driving
	//////////////////////////////

	task automatic strobe_word(input host_word_t w);
		@(posedge clk_sys);
		// no strobe while the core holds the bus
		while (io_wait)
			@(posedge clk_sys);
		io_din <= w;
		io_strobe <= 1'b1;
		@(posedge clk_sys);
		io_strobe <= 1'b0;
	endtask

	task automatic release_wait();
		repeat (8) @(posedge clk_sys);
		ioctl_wait <= 1'b0;
	endtask

	task automatic send_frame(input frame_t f);
		// start right after a ps2 clock rise so no byte leaves before the credit read
		if (f.sync_ps2)
			@(posedge u_dut.ps2_clk);
		@(posedge clk_sys);
		io_enable <= 1'b1;
		strobe_word(f.cmd);
		for (int i = 0; i < f.n_words; i++) begin
			strobe_word(f.w[i]);
			if (i == 0 && f.hold_wait) begin
				ioctl_wait <= 1'b1;
				fork
					release_wait();
				join_none
			end
			if (i == 0 && f.chk_credit) begin
				@(negedge clk_sys);
				u_chk.match_credit(f.exp_credit);
			end
		end
		@(posedge clk_sys);
		io_enable <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		u_chk.match_regs(f.exp_joy, f.exp_status, f.exp_dl);
		if (f.chk_addr)
			u_chk.match_byte_count(f.exp_addr);
	endtask

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > timeout_limit) begin
			$display("timeout: the run did not finish within %0d cycles", timeout_limit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		clk_sys = 1'b0;
		rst = 1'b1;
		io_enable = 1'b0;
		io_strobe = 1'b0;
		io_din = '0;
		ioctl_wait = 1'b0;

		add_frame(CMD_JOY0, 2, 16'h1234, 16'habcd, 1'b0, 1'b0, 1'b0);
		add_frame(CMD_STATUS, 2, 16'h00f1, 16'hc3e7, 1'b0, 1'b0, 1'b0);
		add_frame(CMD_KBD_CREDIT, 1, 16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0);
		add_frame(CMD_FILE_INDEX, 1, 16'h0003, 16'h0000, 1'b0, 1'b0, 1'b0);
		add_frame(CMD_FILE_INFO, 2, 16'h2e62, 16'h696e, 1'b0, 1'b0, 1'b0);
		add_frame(CMD_FILE_TX, 1, 16'h00ff, 16'h0000, 1'b0, 1'b0, 1'b0);
		add_frame(CMD_FILE_TX_DAT, 4, 16'h0000, 16'h0000, 1'b1, 1'b1, 1'b0);
		add_frame(CMD_FILE_TX_DAT, 2, 16'h0000, 16'h0000, 1'b1, 1'b0, 1'b0);
		add_frame(CMD_FILE_TX, 1, 16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0);
		add_frame(CMD_PS2_KBD, 3, 16'h0000, 16'h0000, 1'b1, 1'b0, 1'b1);
		add_frame(CMD_KBD_CREDIT, 1, 16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0);
		add_frame(CMD_PS2_KBD, 2, 16'h0000, 16'h0000, 1'b1, 1'b0, 1'b0);

		// host frames, then 11 ps2 bits per key byte, plus margin
		timeout_limit = tbl.size() * 64 + keys_pushed * 11 * 2 * PS2_HALF_PERIOD
			+ 40 * PS2_HALF_PERIOD + 100;

		repeat (5) @(posedge clk_sys);
		rst <= 1'b0;
		@(negedge clk_sys);
		u_chk.after_reset();

		foreach (tbl[i])
			send_frame(tbl[i]);

		while (u_chk.keys_pending() != 0)
			@(posedge clk_sys);
		repeat (2 * PS2_HALF_PERIOD) @(posedge clk_sys);
		u_chk.match_file_info(cur_index, cur_ext);
		u_chk.wrap_up();

		$display("checks: %0d  value errors: %0d  other errors: %0d",
			u_chk.checks, u_chk.value_errs, u_chk.other_errs);
		if (u_chk.value_errs + u_chk.other_errs == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: project.f
hps_pkg.sv
host_cmd_if.sv
host_frame_fsm.sv
host_regs.sv
file_download.sv
ps2_clk_div.sv
ps2_kbd_tx.sv
hps_io_lite.sv
tb_checker.sv
tb_hps_io.sv
